/* rtl/fetch_cfg.svh */
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// address and instruction width
`define FETCH_XLEN 32

// memory burst shape, four beats of 64 bits per line
`define FETCH_BEAT_WIDTH 64
`define FETCH_BEATS 4

// instructions per line
`define FETCH_LINE_WORDS 8

// instruction queue entries, power of two
`define FETCH_QUEUE_DEPTH 16

// first fetch address out of reset
`define FETCH_RESET_PC 32'h1eceb000

`endif

/* rtl/fetch_pkg.sv */
`default_nettype none

`include "fetch_cfg.svh"

package fetch_pkg;

    typedef logic [`FETCH_XLEN-1:0] addr_t;        // byte address
    typedef logic [`FETCH_XLEN-1:0] word_t;        // one instruction
    typedef logic [`FETCH_BEAT_WIDTH-1:0] beat_t;  // one memory beat

    // beat 0 sits in the low bits
    typedef logic [`FETCH_BEATS*`FETCH_BEAT_WIDTH-1:0] line_t;

    typedef logic [$clog2(`FETCH_LINE_WORDS)-1:0] word_idx_t;

    // queue payload, pc in the upper half
    typedef struct packed {
        addr_t pc;
        word_t inst;
    } fetch_entry_t;

endpackage : fetch_pkg

`default_nettype wire

/* rtl/fetch_pc_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module fetch_pc_gen (
    input   wire                        clk,
    input   wire                        rst,

    input   wire                        bmem_ready_i,
    input   wire                        fill_busy_i,
    input   wire                        redirect_i,
    input   wire    fetch_pkg::addr_t   redirect_addr_i,

    output  logic                       bmem_read_o,
    output  fetch_pkg::addr_t           bmem_addr_o,
    output  logic                       req_o,
    output  fetch_pkg::addr_t           req_pc_o
);

    localparam fetch_pkg::addr_t LINE_BYTES = `FETCH_LINE_WORDS * (`FETCH_XLEN / 8);
    localparam int               OFF_BITS   = $clog2(LINE_BYTES);

    fetch_pkg::addr_t   pc;
    fetch_pkg::addr_t   line_base;
    logic               req_q;      // request pulse, one cycle wide
    logic               issue;

    assign line_base = {pc[`FETCH_XLEN-1:OFF_BITS], {OFF_BITS{1'b0}}};

    // one line in flight at a time, never two requests back to back
    assign issue = bmem_ready_i && !fill_busy_i && !req_q && !redirect_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc    <= `FETCH_RESET_PC;
            req_q <= 1'b0;
        end else begin
            req_q <= issue;
            if (redirect_i) begin
                pc <= redirect_addr_i;          // redirect wins
            end else if (issue) begin
                pc <= line_base + LINE_BYTES;   // next sequential line
            end
        end
    end

    // address and pc held until the next request
    always_ff @(posedge clk) begin
        if (issue) begin
            bmem_addr_o <= line_base;
            req_pc_o    <= pc;
        end
    end

    assign bmem_read_o = req_q;
    assign req_o       = req_q;

endmodule : fetch_pc_gen

`default_nettype wire

/* rtl/line_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module line_assembler (
    input   wire                        clk,
    input   wire                        rst,

    input   wire                        req_i,
    input   wire    fetch_pkg::addr_t   req_pc_i,
    input   wire                        bmem_rvalid_i,
    input   wire    fetch_pkg::beat_t   bmem_rdata_i,
    input   wire                        redirect_i,
    input   wire                        line_take_i,

    output  logic                       fill_busy_o,
    output  logic                       line_valid_o,
    output  fetch_pkg::line_t           line_o,
    output  fetch_pkg::addr_t           line_pc_o
);

    localparam int CNT_W = $clog2(`FETCH_BEATS);

    logic   [CNT_W-1:0]     beat_cnt;
    logic                   filling;        // beats still expected
    logic                   stale;          // redirect seen during this fill
    logic                   held;           // complete line waiting for the unpacker
    logic                   last_beat;
    fetch_pkg::line_t       line_q;
    fetch_pkg::addr_t       pc_q;

    assign last_beat = filling && bmem_rvalid_i && (beat_cnt == CNT_W'(`FETCH_BEATS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            filling  <= 1'b0;
            stale    <= 1'b0;
            held     <= 1'b0;
            beat_cnt <= '0;
        end else begin
            if (req_i) begin
                filling  <= 1'b1;
                stale    <= redirect_i;     // request raced a redirect
                beat_cnt <= '0;
            end else if (filling) begin
                if (bmem_rvalid_i) begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
                if (last_beat) begin
                    filling <= 1'b0;
                    stale   <= 1'b0;
                end else if (redirect_i) begin
                    stale <= 1'b1;          // let the burst finish, then drop it
                end
            end

            // a stale line is never offered downstream
            if (last_beat && !stale && !redirect_i) begin
                held <= 1'b1;
            end else if (redirect_i || line_take_i) begin
                held <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (filling && bmem_rvalid_i) begin
            line_q[beat_cnt*`FETCH_BEAT_WIDTH +: `FETCH_BEAT_WIDTH] <= bmem_rdata_i;
        end
        if (req_i) begin
            pc_q <= req_pc_i;
        end
    end

    // stays high until the line leaves, which stalls the next request
    assign fill_busy_o  = filling || held;
    assign line_valid_o = held;
    assign line_o       = line_q;
    assign line_pc_o    = pc_q;

endmodule : line_assembler

`default_nettype wire

/* rtl/line_unpacker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module line_unpacker (
    input   wire                        clk,
    input   wire                        rst,

    input   wire                        line_valid_i,
    input   wire    fetch_pkg::line_t   line_i,
    input   wire    fetch_pkg::addr_t   line_pc_i,
    input   wire                        full_i,
    input   wire                        redirect_i,

    output  logic                       line_take_o,
    output  logic                       push_o,
    output  fetch_pkg::fetch_entry_t    entry_o
);

    localparam int BYTE_BITS = $clog2(`FETCH_XLEN / 8);
    localparam int IDX_BITS  = $clog2(`FETCH_LINE_WORDS);
    localparam int OFF_BITS  = IDX_BITS + BYTE_BITS;

    logic                               busy_q;
    fetch_pkg::word_idx_t               idx_q;
    logic   [`FETCH_XLEN-OFF_BITS-1:0]  tag_q;      // line base without offset bits
    fetch_pkg::line_t                   line_q;
    logic                               last_word;

    assign last_word = (idx_q == fetch_pkg::word_idx_t'(`FETCH_LINE_WORDS - 1));

    // one word per cycle while the queue has room
    assign push_o = busy_q && !full_i;

    // new line goes in when empty, or back to back with the last word
    assign line_take_o = line_valid_i && !redirect_i && (!busy_q || (push_o && last_word));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            idx_q  <= '0;
        end else if (redirect_i) begin
            busy_q <= 1'b0;
        end else if (line_take_o) begin
            busy_q <= 1'b1;
            idx_q  <= line_pc_i[OFF_BITS-1:BYTE_BITS];  // start at the fetch pc
        end else if (push_o) begin
            if (last_word) begin
                busy_q <= 1'b0;
            end else begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_take_o) begin
            line_q <= line_i;
            tag_q  <= line_pc_i[`FETCH_XLEN-1:OFF_BITS];
        end
    end

    always_comb begin
        entry_o.pc   = {tag_q, idx_q, {BYTE_BITS{1'b0}}};
        entry_o.inst = line_q[idx_q*`FETCH_XLEN +: `FETCH_XLEN];
    end

endmodule : line_unpacker

`default_nettype wire

/* rtl/fetch_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module fetch_queue (
    input   wire                                clk,
    input   wire                                rst,

    input   wire                                push_i,
    input   wire    fetch_pkg::fetch_entry_t    entry_i,
    input   wire                                pop_i,
    input   wire                                flush_i,

    output  logic                               full_o,
    output  logic                               valid_o,
    output  fetch_pkg::fetch_entry_t            entry_o
);

    localparam int DEPTH = `FETCH_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    fetch_pkg::fetch_entry_t    mem_q [DEPTH];
    logic   [PTR_W-1:0]         wr_ptr;
    logic   [PTR_W-1:0]         rd_ptr;
    logic   [PTR_W:0]           count;
    logic                       do_push;
    logic                       do_pop;

    assign full_o  = (count == (PTR_W + 1)'(DEPTH));
    assign valid_o = (count != '0);
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && valid_o;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr <= '0;       // flush drops everything, incoming push too
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr] <= entry_i;
        end
    end

    assign entry_o = mem_q[rd_ptr];     // head shown directly

endmodule : fetch_queue

`default_nettype wire

/* rtl/fetch_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend (
    input   wire                        clk,
    input   wire                        rst,

    output  logic                       bmem_read_o,
    output  fetch_pkg::addr_t           bmem_addr_o,
    input   wire                        bmem_ready_i,
    input   wire                        bmem_rvalid_i,
    input   wire    fetch_pkg::beat_t   bmem_rdata_i,

    input   wire                        redirect_i,
    input   wire    fetch_pkg::addr_t   redirect_addr_i,

    output  logic                       inst_valid_o,
    output  fetch_pkg::addr_t           inst_pc_o,
    output  fetch_pkg::word_t           inst_o,
    input   wire                        dequeue_i
);

    logic                       req;
    fetch_pkg::addr_t           req_pc;
    logic                       fill_busy;
    logic                       line_valid;
    fetch_pkg::line_t           line;
    fetch_pkg::addr_t           line_pc;
    logic                       line_take;
    logic                       push;
    fetch_pkg::fetch_entry_t    push_entry;
    logic                       queue_full;
    fetch_pkg::fetch_entry_t    head_entry;

    fetch_pc_gen pc_gen_i (
        .clk             (clk),
        .rst             (rst),
        .bmem_ready_i    (bmem_ready_i),
        .fill_busy_i     (fill_busy),
        .redirect_i      (redirect_i),
        .redirect_addr_i (redirect_addr_i),
        .bmem_read_o     (bmem_read_o),
        .bmem_addr_o     (bmem_addr_o),
        .req_o           (req),
        .req_pc_o        (req_pc)
    );

    line_assembler line_asm_i (
        .clk           (clk),
        .rst           (rst),
        .req_i         (req),
        .req_pc_i      (req_pc),
        .bmem_rvalid_i (bmem_rvalid_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .redirect_i    (redirect_i),
        .line_take_i   (line_take),
        .fill_busy_o   (fill_busy),
        .line_valid_o  (line_valid),
        .line_o        (line),
        .line_pc_o     (line_pc)
    );

    line_unpacker unpacker_i (
        .clk          (clk),
        .rst          (rst),
        .line_valid_i (line_valid),
        .line_i       (line),
        .line_pc_i    (line_pc),
        .full_i       (queue_full),
        .redirect_i   (redirect_i),
        .line_take_o  (line_take),
        .push_o       (push),
        .entry_o      (push_entry)
    );

    fetch_queue queue_i (
        .clk     (clk),
        .rst     (rst),
        .push_i  (push),
        .entry_i (push_entry),
        .pop_i   (dequeue_i),
        .flush_i (redirect_i),      // redirect empties the queue
        .full_o  (queue_full),
        .valid_o (inst_valid_o),
        .entry_o (head_entry)
    );

    assign inst_pc_o = head_entry.pc;
    assign inst_o    = head_entry.inst;

endmodule : fetch_frontend

`default_nettype wire

/* bench/tb_fetch_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module tb_fetch_frontend;

    localparam logic [31:0] KEY         = 32'ha20c0ffe;     // memory word = address ^ key
    localparam logic [31:0] REDIRECT_PC = 32'h1eceb114;
    localparam logic [31:0] LINE_BYTES  = 32'(`FETCH_LINE_WORDS * 4);
    localparam int          TOTAL_WORDS = 40 + 48 + 24 + 200;
    localparam int          WAIT_LIMIT  = 500;
    localparam int          WATCHDOG_CYCLES = 10 + TOTAL_WORDS * 30 + 3 * WAIT_LIMIT;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   bmem_read, bmem_ready = 1'b1, bmem_rvalid = 1'b0;
    logic [31:0]            bmem_addr;
    logic [63:0]            bmem_rdata = '0;
    logic                   redirect, dequeue, inst_valid;
    logic [31:0]            redirect_addr, inst_pc, inst;

    logic [31:0]            lcg_state = 32'd11895;
    int                     errors = 0, checks = 0, req_count = 0, beats_sent = 0;
    logic                   mem_busy = 1'b0, beat_gaps = 1'b0, ready_toggle = 1'b0;
    logic                   ready_at_edge = 1'b1;   // bmem_ready seen by the last rising edge
    logic [31:0]            exp_pc = `FETCH_RESET_PC;
    logic [31:0]            exp_req_addr = `FETCH_RESET_PC;
    logic [31:0]            first_addr = '0;

    fetch_frontend fetch_frontend_i (
        .clk             (clk),
        .rst             (rst),
        .bmem_read_o     (bmem_read),
        .bmem_addr_o     (bmem_addr),
        .bmem_ready_i    (bmem_ready),
        .bmem_rvalid_i   (bmem_rvalid),
        .bmem_rdata_i    (bmem_rdata),
        .redirect_i      (redirect),
        .redirect_addr_i (redirect_addr),
        .inst_valid_o    (inst_valid),
        .inst_pc_o       (inst_pc),
        .inst_o          (inst),
        .dequeue_i       (dequeue)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {16'd0, lcg_state[31:16]};     // upper half of the state
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ KEY;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    // call right after a falling edge; pops the head if it is taken
    task automatic consume_step(input string name, input logic rnd, output logic taken);
        taken   = 1'b0;
        dequeue = 1'b0;
        if (inst_valid && (!rnd || next_rand() % 32'd3 != 32'd0)) begin
            check_value({name, " pc"}, exp_pc, inst_pc);
            check_value({name, " inst"}, mem_word(exp_pc), inst);
            exp_pc  = exp_pc + 32'd4;
            dequeue = 1'b1;
            taken   = 1'b1;
        end
    endtask

    task automatic take_words(input string name, input int count, input logic rnd);
        int   got;
        logic taken;
        got = 0;
        while (got < count) begin
            @(negedge clk);
            consume_step(name, rnd, taken);
            if (taken) got++;
        end
        @(negedge clk);
        dequeue = 1'b0;
    endtask

    task automatic check_reset();
        int n;
        repeat (10) begin
            @(posedge clk);
            @(negedge clk);
            check_value("reset inst_valid", 32'd0, {31'd0, inst_valid});
            check_value("reset bmem_read", 32'd0, {31'd0, bmem_read});
        end
        rst = 1'b0;
        n = 0;
        while (req_count == 0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (req_count == 0) report_failure("reset: no line request after reset");
        else check_value("reset first request", `FETCH_RESET_PC, first_addr);
    endtask

    task automatic hold_backpressure();
        int   idle, n, last_count;
        logic seen_valid;
        idle = 0;
        n = 0;
        last_count = req_count;
        seen_valid = 1'b0;
        while (idle < 50 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
            if (seen_valid) check_value("backpressure inst_valid", 32'd1, {31'd0, inst_valid});
            seen_valid = seen_valid || inst_valid;
            if (req_count != last_count) begin
                idle = 0;
                last_count = req_count;
            end else begin
                idle++;
            end
        end
        if (idle < 50) report_failure("backpressure: requests kept coming with the queue full");
        take_words("backpressure", 48, 1'b0);
    endtask

    task automatic redirect_midburst();
        int   n;
        logic taken, fired;
        n = 0;
        fired = 1'b0;
        while (!fired && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
            if (mem_busy && beats_sent >= 1 && beats_sent <= 3) begin
                dequeue       = 1'b0;
                redirect      = 1'b1;
                redirect_addr = REDIRECT_PC;
                exp_req_addr  = REDIRECT_PC & ~(LINE_BYTES - 32'd1);
                fired         = 1'b1;
            end else begin
                consume_step("redirect lead-in", 1'b0, taken);
            end
        end
        if (!fired) begin
            report_failure("redirect: never caught a burst in flight");
        end else begin
            @(negedge clk);
            redirect = 1'b0;
            exp_pc   = REDIRECT_PC;     // nothing older may show up now
            take_words("redirect", 24, 1'b0);
        end
    endtask

    task automatic random_timing();
        beat_gaps    = 1'b1;
        ready_toggle = 1'b1;
        take_words("random", 200, 1'b1);
    endtask

    always @(posedge clk) ready_at_edge <= bmem_ready;

    // one line per request with beat k holding words 2k and 2k+1
    initial begin : memory_model
        logic [31:0] base;
        int          gap;
        forever begin
            @(negedge clk);
            if (!rst && bmem_read) begin
                base = bmem_addr;
                if (req_count == 0) first_addr = base;
                if (!ready_at_edge) begin
                    report_failure("memory: read request issued while bmem_ready was low");
                end
                check_value("request address", exp_req_addr, base);
                exp_req_addr = exp_req_addr + LINE_BYTES;
                req_count++;
                mem_busy   = 1'b1;
                beats_sent = 0;
                gap = 1 + int'(next_rand() % 32'd4);
                repeat (gap) @(negedge clk);
                for (int k = 0; k < `FETCH_BEATS; k++) begin
                    bmem_rdata  = {mem_word(base + 32'(8 * k) + 32'd4), mem_word(base + 32'(8 * k))};
                    bmem_rvalid = 1'b1;
                    beats_sent++;
                    @(negedge clk);
                    bmem_rvalid = 1'b0;
                    if (beat_gaps && k < `FETCH_BEATS - 1) begin
                        repeat (int'(next_rand() % 32'd3)) @(negedge clk);
                    end
                end
                mem_busy = 1'b0;    // next request may follow right after the last beat
            end
        end
    end

    initial begin : ready_driver
        forever begin
            @(negedge clk);
            if (ready_toggle) bmem_ready = (next_rand() % 32'd4) != 32'd0;
            else bmem_ready = 1'b1;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rst           = 1'b1;
        redirect      = 1'b0;
        redirect_addr = '0;
        dequeue       = 1'b0;
        check_reset();
        take_words("sequential", 40, 1'b0);
        hold_backpressure();
        redirect_midburst();
        random_timing();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule : tb_fetch_frontend

`default_nettype wire

/* filelist.f */
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_pc_gen.sv
rtl/line_assembler.sv
rtl/line_unpacker.sv
rtl/fetch_queue.sv
rtl/fetch_frontend.sv
bench/tb_fetch_frontend.sv

/* Makefile */
TOP = tb_fetch_frontend

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) \
		-f filelist.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
